// File: all.f
source/tex_cache_pkg.sv
source/client_crossbar.sv
source/cache_unit.sv
source/mem_arbiter.sv
source/fill_address_gen.sv
source/tex_cache_l2.sv
tests/tb_memory_model.sv
tests/tb_tex_cache_l2.sv

// File: run.sh
#!/bin/sh
# build with Verilator and run, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_tex_cache_l2 -f all.f &&
./obj_dir/Vtb_tex_cache_l2 | tee /dev/stderr | grep -qx ">>> PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tests/tb_tex_cache_l2.sv
/*
 * testbench for the L2 texture cache
 * clock and reset, a memory model, response and burst monitors,
 * directed tests and compare tasks
 */
`timescale 1ns/1ns
`default_nettype none

module tb_tex_cache_l2;
	import tex_cache_pkg::*;

	localparam int STRIDE = 64;
	localparam int TIMEOUT_CYCLES = 200;

	logic clk;
	logic reset;
	logic clear_start;
	logic clear_busy;
	mem_addr_t param_stride;
	addr_x_t s_araddrx;
	addr_y_t s_araddry;
	req_id_t s_arid;
	logic s_arvalid;
	logic s_arready;
	texel_t s_rdata;
	req_id_t s_rid;
	logic s_rvalid;
	logic s_rready;
	mem_addr_t mem_araddr;
	logic mem_arvalid;
	logic mem_arready;
	mem_word_u mem_rdata;
	logic mem_rlast;
	logic mem_rvalid;

	int seed = 85776;
	int burst_count;
	mem_addr_t last_burst_addr;
	texel_t rsp_data_q[$];
	req_id_t rsp_id_q[$];
	texel_t exp_texel[16];
	bit issued[16];
	logic prev_stall;
	texel_t prev_data;
	req_id_t prev_id;

	tex_cache_l2 #(
		.PARALLEL_SIZE(1),
		.TAG_ADDR_WIDTH(4)
	) DUT (
		.clk(clk),
		.reset(reset),
		.clear_start(clear_start),
		.clear_busy(clear_busy),
		.param_stride(param_stride),
		.s_araddrx(s_araddrx),
		.s_araddry(s_araddry),
		.s_arid(s_arid),
		.s_arvalid(s_arvalid),
		.s_arready(s_arready),
		.s_rdata(s_rdata),
		.s_rid(s_rid),
		.s_rvalid(s_rvalid),
		.s_rready(s_rready),
		.mem_araddr(mem_araddr),
		.mem_arvalid(mem_arvalid),
		.mem_arready(mem_arready),
		.mem_rdata(mem_rdata),
		.mem_rlast(mem_rlast),
		.mem_rvalid(mem_rvalid)
	);

	tb_memory_model memory (
		.clk(clk),
		.reset(reset),
		.mem_araddr(mem_araddr),
		.mem_arvalid(mem_arvalid),
		.mem_arready(mem_arready),
		.mem_rdata(mem_rdata),
		.mem_rlast(mem_rlast),
		.mem_rvalid(mem_rvalid)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// --------------------------------------------------
	// reference model of the texture layout
	// --------------------------------------------------
	function automatic texel_t expected_texel(addr_x_t x, addr_y_t y);
		int xi;
		int yi;
		int word_addr;
		xi = int'(x);
		yi = int'(y);
		word_addr = (yi / 4) * STRIDE + (xi / 4) * BLK_WORDS + yi % 4;
		return texel_t'((4 * word_addr + xi % 4) ^ 'h5A);
	endfunction

	// burst start, row 0 of the block
	function automatic mem_addr_t expected_addr(addr_x_t x, addr_y_t y);
		return mem_addr_t'((int'(y) / 4) * STRIDE + (int'(x) / 4) * BLK_WORDS);
	endfunction

	// --------------------------------------------------
	// failure reporting and compare tasks
	// --------------------------------------------------
	task automatic end_in_failure();
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_failure(string msg);
		$display("%s at t=%0t", msg, $time);
		end_in_failure();
	endtask

	task automatic report_timeout(string what);
		report_failure($sformatf("timeout while waiting for %s", what));
	endtask

	task automatic compare_texel(string name, texel_t got, texel_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s expected %h got %h", $time, name, exp, got);
			end_in_failure();
		end
	endtask

	task automatic compare_id(string name, req_id_t got, req_id_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s expected %h got %h", $time, name, exp, got);
			end_in_failure();
		end
	endtask

	task automatic compare_addr(string name, mem_addr_t got, mem_addr_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s expected %h got %h", $time, name, exp, got);
			end_in_failure();
		end
	endtask

	task automatic compare_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s expected %b got %b", $time, name, exp, got);
			end_in_failure();
		end
	endtask

	task automatic compare_count(string name, int got, int exp);
		if (got != exp) begin
			$display("ERR t=%0t %s expected %0d got %0d", $time, name, exp, got);
			end_in_failure();
		end
	endtask

	// --------------------------------------------------
	// monitors, sampled mid-cycle
	// --------------------------------------------------
	initial begin
		burst_count = 0;
		last_burst_addr = '0;
		prev_stall = 1'b0;
		prev_data = '0;
		prev_id = '0;
	end

	always @(negedge clk) begin
		if (!reset && mem_arvalid && mem_arready) begin
			burst_count++;
			last_burst_addr = mem_araddr;
		end
	end

	always @(negedge clk) begin
		if (reset) begin
			prev_stall = 1'b0;
		end else begin
			// a stalled response must stay put
			if (prev_stall) begin
				compare_bit("s_rvalid", s_rvalid, 1'b1);
				compare_texel("s_rdata", s_rdata, prev_data);
				compare_id("s_rid", s_rid, prev_id);
			end
			if (s_rvalid && s_rready) begin
				rsp_data_q.push_back(s_rdata);
				rsp_id_q.push_back(s_rid);
			end
			prev_stall = s_rvalid && !s_rready;
			prev_data = s_rdata;
			prev_id = s_rid;
		end
	end

	// --------------------------------------------------
	// drivers and waits, each ends just after a rising edge
	// --------------------------------------------------
	task automatic send_request(addr_x_t x, addr_y_t y, req_id_t id);
		int waited;
		waited = 0;
		s_araddrx = x;
		s_araddry = y;
		s_arid = id;
		s_arvalid = 1'b1;
		@(negedge clk);
		while (!s_arready) begin
			if (waited == TIMEOUT_CYCLES) report_timeout("s_arready");
			waited++;
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		s_arvalid = 1'b0;
	endtask

	task automatic issue_read(addr_x_t x, addr_y_t y, req_id_t id);
		exp_texel[int'(id)] = expected_texel(x, y);
		issued[int'(id)] = 1'b1;
		send_request(x, y, id);
	endtask

	task automatic wait_responses(int target);
		int waited;
		waited = 0;
		while (rsp_data_q.size() < target) begin
			if (waited == TIMEOUT_CYCLES) report_timeout("a read response");
			waited++;
			@(posedge clk);
			#1;
		end
	endtask

	task automatic wait_rvalid();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!s_rvalid) begin
			if (waited == TIMEOUT_CYCLES) report_timeout("s_rvalid");
			waited++;
			@(negedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic wait_clear_done();
		int waited;
		waited = 0;
		@(negedge clk);
		while (clear_busy) begin
			if (waited == TIMEOUT_CYCLES) report_timeout("the end of the clear sweep");
			waited++;
			@(negedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	// each response must match one outstanding id exactly once
	task automatic check_batch(int base, int count);
		req_id_t id;
		for (int i = base; i < base + count; i++) begin
			id = rsp_id_q[i];
			if (!issued[int'(id)]) begin
				report_failure($sformatf("response with unexpected or repeated id %0d", id));
			end
			issued[int'(id)] = 1'b0;
			compare_texel("s_rdata", rsp_data_q[i], exp_texel[int'(id)]);
		end
	endtask

	task automatic check_single_read(addr_x_t x, addr_y_t y, req_id_t id, bit expect_burst);
		int base;
		int bursts_before;
		base = rsp_data_q.size();
		bursts_before = burst_count;
		issue_read(x, y, id);
		wait_responses(base + 1);
		compare_id("s_rid", rsp_id_q[base], id);
		check_batch(base, 1);
		if (expect_burst) begin
			compare_count("burst count", burst_count, bursts_before + 1);
			compare_addr("mem_araddr", last_burst_addr, expected_addr(x, y));
		end else begin
			compare_count("burst count", burst_count, bursts_before);
		end
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic test_reset_state();
		int waited;
		waited = 0;
		@(negedge clk);
		compare_bit("s_rvalid", s_rvalid, 1'b0);
		compare_bit("mem_arvalid", mem_arvalid, 1'b0);
		compare_bit("clear_busy", clear_busy, 1'b0);
		while (!s_arready) begin
			if (waited == TIMEOUT_CYCLES) report_timeout("s_arready after reset");
			waited++;
			@(negedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic test_miss_then_hit();
		check_single_read(8'd5, 8'd9, 4'd3, 1'b1);
		// same block, must hit
		check_single_read(8'd6, 8'd10, 4'd4, 1'b0);
	endtask

	task automatic test_random_reads();
		int base;
		addr_x_t x;
		addr_y_t y;
		base = rsp_data_q.size();
		for (int i = 0; i < 8; i++) begin
			x = addr_x_t'($random(seed));
			y = addr_y_t'($random(seed));
			// alternate the owning unit
			if (x[BLK_X_SIZE] ^ y[BLK_Y_SIZE] ^ i[0]) begin
				x[BLK_X_SIZE] = ~x[BLK_X_SIZE];
			end
			issue_read(x, y, req_id_t'(i));
		end
		wait_responses(base + 8);
		check_batch(base, 8);
	endtask

	task automatic test_backpressure();
		int base;
		base = rsp_data_q.size();
		s_rready = 1'b0;
		// blocks on different units
		issue_read(8'd0, 8'd0, 4'd9);
		issue_read(8'd4, 8'd0, 4'd10);
		wait_rvalid();
		repeat (6) @(posedge clk);
		#1;
		s_rready = 1'b1;
		wait_responses(base + 2);
		check_batch(base, 2);
		repeat (10) @(posedge clk);
		#1;
		compare_count("response count", rsp_data_q.size(), base + 2);
	endtask

	task automatic test_clear();
		int base;
		base = rsp_data_q.size();
		// random reads may have evicted this line
		issue_read(8'd5, 8'd9, 4'd11);
		wait_responses(base + 1);
		check_batch(base, 1);
		check_single_read(8'd5, 8'd9, 4'd12, 1'b0);
		clear_start = 1'b1;
		@(posedge clk);
		#1;
		clear_start = 1'b0;
		@(negedge clk);
		compare_bit("clear_busy", clear_busy, 1'b1);
		wait_clear_done();
		check_single_read(8'd5, 8'd9, 4'd15, 1'b1);
	endtask

	// block (0,0) and (8,0): same unit and index, different tag
	task automatic test_eviction();
		for (int i = 0; i < 3; i++) begin
			check_single_read(8'd1, 8'd2, 4'd13, 1'b1);
			check_single_read(8'd33, 8'd3, 4'd14, 1'b1);
		end
	endtask

	initial begin
		reset = 1'b1;
		clear_start = 1'b0;
		param_stride = mem_addr_t'(STRIDE);
		s_araddrx = '0;
		s_araddry = '0;
		s_arid = '0;
		s_arvalid = 1'b0;
		s_rready = 1'b1;
		for (int i = 0; i < 16; i++) begin
			issued[i] = 1'b0;
			exp_texel[i] = '0;
		end
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		test_reset_state();
		test_miss_then_hit();
		test_random_reads();
		test_backpressure();
		test_clear();
		test_eviction();

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/tb_memory_model.sv
/*
 * behavioral memory for the texture cache testbench
 * one burst at a time, four words after a short delay,
 * word contents follow a fixed rule of the address
 */
`timescale 1ns/1ns
`default_nettype none

module tb_memory_model (
	input wire clk,
	input wire reset,
	input wire tex_cache_pkg::mem_addr_t mem_araddr,
	input wire mem_arvalid,
	output logic mem_arready,
	output tex_cache_pkg::mem_word_u mem_rdata,
	output logic mem_rlast,
	output logic mem_rvalid
);
	import tex_cache_pkg::*;

	// idle cycles between acceptance and the first word
	localparam int DELAY = 3;

	logic busy;
	int step;
	mem_addr_t base;
	logic take;
	logic in_reset;
	mem_addr_t take_addr;

	// texel k of word A is (4A + k) xor 0x5a
	function automatic mem_word_u word_at(mem_addr_t addr);
		mem_word_u w;
		w = '0;
		for (int k = 0; k < TEXELS_PER_WORD; k++) begin
			w.texels[k] = texel_t'((4 * int'(addr) + k) ^ 'h5A);
		end
		return w;
	endfunction

	task automatic drive_outputs();
		mem_arready = !busy;
		mem_rvalid = busy && step >= DELAY;
		mem_rlast = mem_rvalid && step == DELAY + BLK_WORDS - 1;
		mem_rdata = mem_rvalid ? word_at(mem_addr_t'(int'(base) + step - DELAY)) : '0;
	endtask

	// --------------------------------------------------
	// sample mid-cycle, drive just after the rising edge
	// --------------------------------------------------
	initial begin
		busy = 1'b0;
		step = 0;
		base = '0;
		drive_outputs();
		forever begin
			@(negedge clk);
			in_reset = reset;
			take = mem_arvalid && mem_arready;
			take_addr = mem_araddr;
			@(posedge clk);
			#1;
			if (in_reset) begin
				busy = 1'b0;
				step = 0;
			end else if (busy) begin
				step++;
				if (step == DELAY + BLK_WORDS) begin
					busy = 1'b0;
				end
			end else if (take) begin
				busy = 1'b1;
				step = 0;
				base = take_addr;
			end
			drive_outputs();
		end
	end

endmodule

`default_nettype wire

// File: source/tex_cache_l2.sv
/*
 * L2 texture cache top level
 * client crossbar, parallel cache units, memory arbiter
 * and the fill address pipeline
 */
`timescale 1ns/1ns
`default_nettype none

module tex_cache_l2 #(
	parameter int PARALLEL_SIZE = 1,
	parameter int TAG_ADDR_WIDTH = 4
) (
	input wire clk,
	input wire reset,
	input wire clear_start,
	output logic clear_busy,
	input wire tex_cache_pkg::mem_addr_t param_stride,
	input wire tex_cache_pkg::addr_x_t s_araddrx,
	input wire tex_cache_pkg::addr_y_t s_araddry,
	input wire tex_cache_pkg::req_id_t s_arid,
	input wire s_arvalid,
	output logic s_arready,
	output tex_cache_pkg::texel_t s_rdata,
	output tex_cache_pkg::req_id_t s_rid,
	output logic s_rvalid,
	input wire s_rready,
	output tex_cache_pkg::mem_addr_t mem_araddr,
	output logic mem_arvalid,
	input wire mem_arready,
	input wire tex_cache_pkg::mem_word_u mem_rdata,
	input wire mem_rlast,
	input wire mem_rvalid
);
	import tex_cache_pkg::*;

	localparam int UNIT_NUM = 1 << PARALLEL_SIZE;

	addr_x_t [UNIT_NUM-1:0] unit_req_x;
	addr_y_t [UNIT_NUM-1:0] unit_req_y;
	req_id_t [UNIT_NUM-1:0] unit_req_id;
	logic [UNIT_NUM-1:0] unit_req_valid;
	logic [UNIT_NUM-1:0] unit_req_ready;
	texel_t [UNIT_NUM-1:0] unit_rsp_texel;
	req_id_t [UNIT_NUM-1:0] unit_rsp_id;
	logic [UNIT_NUM-1:0] unit_rsp_valid;
	logic [UNIT_NUM-1:0] unit_rsp_ready;
	blk_x_t [UNIT_NUM-1:0] fill_req_bx;
	blk_y_t [UNIT_NUM-1:0] fill_req_by;
	logic [UNIT_NUM-1:0] fill_req_valid;
	logic [UNIT_NUM-1:0] fill_req_ready;
	mem_word_u fill_wdata;
	logic fill_wlast;
	logic [UNIT_NUM-1:0] fill_wvalid;
	logic [UNIT_NUM-1:0] unit_clear_busy;
	blk_x_t gen_bx;
	blk_y_t gen_by;
	logic gen_valid;
	logic gen_ready;

	// busy until the slowest unit ends its sweep
	assign clear_busy = |unit_clear_busy;

	client_crossbar #(
		.PARALLEL_SIZE(PARALLEL_SIZE)
	) i_client_crossbar (
		.clk(clk),
		.reset(reset),
		.s_araddrx(s_araddrx),
		.s_araddry(s_araddry),
		.s_arid(s_arid),
		.s_arvalid(s_arvalid),
		.s_arready(s_arready),
		.s_rdata(s_rdata),
		.s_rid(s_rid),
		.s_rvalid(s_rvalid),
		.s_rready(s_rready),
		.unit_req_x(unit_req_x),
		.unit_req_y(unit_req_y),
		.unit_req_id(unit_req_id),
		.unit_req_valid(unit_req_valid),
		.unit_req_ready(unit_req_ready),
		.unit_rsp_texel(unit_rsp_texel),
		.unit_rsp_id(unit_rsp_id),
		.unit_rsp_valid(unit_rsp_valid),
		.unit_rsp_ready(unit_rsp_ready)
	);

	// --------------------------------------------------
	// cache units
	// --------------------------------------------------
	for (genvar i = 0; i < UNIT_NUM; i++) begin : g_unit
		cache_unit #(
			.TAG_ADDR_WIDTH(TAG_ADDR_WIDTH),
			.PARALLEL_SIZE(PARALLEL_SIZE)
		) i_cache_unit (
			.clk(clk),
			.reset(reset),
			.clear_start(clear_start),
			.clear_busy(unit_clear_busy[i]),
			.req_x(unit_req_x[i]),
			.req_y(unit_req_y[i]),
			.req_id(unit_req_id[i]),
			.req_valid(unit_req_valid[i]),
			.req_ready(unit_req_ready[i]),
			.rsp_texel(unit_rsp_texel[i]),
			.rsp_id(unit_rsp_id[i]),
			.rsp_valid(unit_rsp_valid[i]),
			.rsp_ready(unit_rsp_ready[i]),
			.fill_req_bx(fill_req_bx[i]),
			.fill_req_by(fill_req_by[i]),
			.fill_req_valid(fill_req_valid[i]),
			.fill_req_ready(fill_req_ready[i]),
			.fill_wdata(fill_wdata),
			.fill_wlast(fill_wlast),
			.fill_wvalid(fill_wvalid[i])
		);
	end

	mem_arbiter #(
		.PARALLEL_SIZE(PARALLEL_SIZE)
	) i_mem_arbiter (
		.clk(clk),
		.reset(reset),
		.fill_req_bx(fill_req_bx),
		.fill_req_by(fill_req_by),
		.fill_req_valid(fill_req_valid),
		.fill_req_ready(fill_req_ready),
		.fill_wdata(fill_wdata),
		.fill_wlast(fill_wlast),
		.fill_wvalid(fill_wvalid),
		.gen_bx(gen_bx),
		.gen_by(gen_by),
		.gen_valid(gen_valid),
		.gen_ready(gen_ready),
		.mem_rdata(mem_rdata),
		.mem_rlast(mem_rlast),
		.mem_rvalid(mem_rvalid)
	);

	fill_address_gen i_fill_address_gen (
		.clk(clk),
		.reset(reset),
		.param_stride(param_stride),
		.gen_bx(gen_bx),
		.gen_by(gen_by),
		.gen_valid(gen_valid),
		.gen_ready(gen_ready),
		.mem_araddr(mem_araddr),
		.mem_arvalid(mem_arvalid),
		.mem_arready(mem_arready)
	);

endmodule

`default_nettype wire

// File: source/fill_address_gen.sv
/*
 * fill address pipeline
 * block coordinate to burst start address in two stages
 */
`timescale 1ns/1ns
`default_nettype none

module fill_address_gen (
	input wire clk,
	input wire reset,
	input wire tex_cache_pkg::mem_addr_t param_stride,
	input wire tex_cache_pkg::blk_x_t gen_bx,
	input wire tex_cache_pkg::blk_y_t gen_by,
	input wire gen_valid,
	output logic gen_ready,
	output tex_cache_pkg::mem_addr_t mem_araddr,
	output logic mem_arvalid,
	input wire mem_arready
);
	import tex_cache_pkg::*;

	mem_addr_t st0_row;
	mem_addr_t st0_col;
	logic st0_valid;
	logic advance;

	// both stages move together
	assign advance = !mem_arvalid || mem_arready;
	assign gen_ready = advance;

	always_ff @(posedge clk) begin
		if (reset) begin
			st0_valid <= 1'b0;
			mem_arvalid <= 1'b0;
		end else if (advance) begin
			st0_valid <= gen_valid;
			mem_arvalid <= st0_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			// stage 0, row pitch and block column offset
			st0_row <= mem_addr_t'(gen_by * param_stride);
			st0_col <= mem_addr_t'(gen_bx * BLK_WORDS);
			// stage 1
			mem_araddr <= st0_row + st0_col;
		end
	end

endmodule

`default_nettype wire

// File: source/mem_arbiter.sv
/*
 * memory read port arbiter
 * round-robin grant per burst, burst words routed to the
 * granted unit until rlast
 */
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter #(
	parameter int PARALLEL_SIZE = 1,
	localparam int UNIT_NUM = 1 << PARALLEL_SIZE
) (
	input wire clk,
	input wire reset,
	input wire tex_cache_pkg::blk_x_t [UNIT_NUM-1:0] fill_req_bx,
	input wire tex_cache_pkg::blk_y_t [UNIT_NUM-1:0] fill_req_by,
	input wire [UNIT_NUM-1:0] fill_req_valid,
	output logic [UNIT_NUM-1:0] fill_req_ready,
	output tex_cache_pkg::mem_word_u fill_wdata,
	output logic fill_wlast,
	output logic [UNIT_NUM-1:0] fill_wvalid,
	output tex_cache_pkg::blk_x_t gen_bx,
	output tex_cache_pkg::blk_y_t gen_by,
	output logic gen_valid,
	input wire gen_ready,
	input wire tex_cache_pkg::mem_word_u mem_rdata,
	input wire mem_rlast,
	input wire mem_rvalid
);
	logic [UNIT_NUM-1:0] grant;
	logic [PARALLEL_SIZE-1:0] rr_ptr;
	logic [PARALLEL_SIZE-1:0] pick;
	logic pick_valid;
	logic accept;

	always_comb begin
		logic [PARALLEL_SIZE-1:0] cand;
		pick = rr_ptr;
		pick_valid = 1'b0;
		for (int k = UNIT_NUM - 1; k >= 0; k--) begin
			cand = rr_ptr + PARALLEL_SIZE'(k);
			if (fill_req_valid[cand]) begin
				pick = cand;
				pick_valid = 1'b1;
			end
		end
	end

	// new burst only while no grant is held
	assign gen_valid = grant == '0 && pick_valid;
	assign gen_bx = fill_req_bx[pick];
	assign gen_by = fill_req_by[pick];
	assign accept = gen_valid && gen_ready;

	always_comb begin
		fill_req_ready = '0;
		fill_req_ready[pick] = accept;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			grant <= '0;
			rr_ptr <= '0;
		end else if (accept) begin
			grant <= UNIT_NUM'(1) << pick;
			rr_ptr <= pick + 1'b1;
		end else if (mem_rvalid && mem_rlast) begin
			grant <= '0;
		end
	end

	// --------------------------------------------------
	// read data toward the granted unit
	// --------------------------------------------------
	assign fill_wdata = mem_rdata;
	assign fill_wlast = mem_rlast;
	assign fill_wvalid = mem_rvalid ? grant : '0;

	assert property (@(posedge clk) disable iff (reset) $onehot0(grant));

endmodule

`default_nettype wire

// File: source/cache_unit.sv
/*
 * direct-mapped block cache unit
 * tag and data arrays, miss fill from the arbiter,
 * clear sweep over all tags
 */
`timescale 1ns/1ns
`default_nettype none

module cache_unit #(
	parameter int TAG_ADDR_WIDTH = 4,
	parameter int PARALLEL_SIZE = 1
) (
	input wire clk,
	input wire reset,
	input wire clear_start,
	output logic clear_busy,
	input wire tex_cache_pkg::addr_x_t req_x,
	input wire tex_cache_pkg::addr_y_t req_y,
	input wire tex_cache_pkg::req_id_t req_id,
	input wire req_valid,
	output logic req_ready,
	output tex_cache_pkg::texel_t rsp_texel,
	output tex_cache_pkg::req_id_t rsp_id,
	output logic rsp_valid,
	input wire rsp_ready,
	output tex_cache_pkg::blk_x_t fill_req_bx,
	output tex_cache_pkg::blk_y_t fill_req_by,
	output logic fill_req_valid,
	input wire fill_req_ready,
	input wire tex_cache_pkg::mem_word_u fill_wdata,
	input wire fill_wlast,
	input wire fill_wvalid
);
	import tex_cache_pkg::*;

	localparam int TAG_NUM = 1 << TAG_ADDR_WIDTH;
	localparam int IDX_X_WIDTH = TAG_ADDR_WIDTH / 2;
	localparam int IDX_Y_WIDTH = TAG_ADDR_WIDTH - IDX_X_WIDTH;
	// unit bits of bx follow from by and the unit id, so the tag skips them
	localparam int TAG_X_WIDTH = BLK_X_WIDTH - PARALLEL_SIZE - IDX_X_WIDTH;
	localparam int TAG_Y_WIDTH = BLK_Y_WIDTH - IDX_Y_WIDTH;
	localparam int TAG_WIDTH = TAG_X_WIDTH + TAG_Y_WIDTH;
	localparam int ROW_WIDTH = $clog2(BLK_WORDS);

	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_LOOKUP = 3'd1;
	localparam logic [2:0] ST_FILL_REQ = 3'd2;
	localparam logic [2:0] ST_FILL = 3'd3;
	localparam logic [2:0] ST_READ = 3'd4;
	localparam logic [2:0] ST_RESP = 3'd5;

	logic [2:0] state;
	addr_x_t cur_x;
	addr_y_t cur_y;
	req_id_t cur_id;
	blk_x_t cur_bx;
	blk_y_t cur_by;
	logic [TAG_ADDR_WIDTH-1:0] cur_index;
	logic [TAG_WIDTH-1:0] cur_tag;
	logic hit;
	logic [ROW_WIDTH-1:0] fill_row;
	logic [TAG_ADDR_WIDTH-1:0] clear_idx;
	logic [TAG_NUM-1:0] tag_valid;
	logic [TAG_WIDTH-1:0] tag_mem [TAG_NUM];
	logic [WORD_WIDTH-1:0] data_mem [TAG_NUM*BLK_WORDS];
	mem_word_u rd_word;

	// --------------------------------------------------
	// index and tag split
	// --------------------------------------------------
	assign cur_bx = cur_x[ADDR_X_WIDTH-1:BLK_X_SIZE];
	assign cur_by = cur_y[ADDR_Y_WIDTH-1:BLK_Y_SIZE];
	assign cur_index = {cur_by[IDX_Y_WIDTH-1:0], cur_bx[PARALLEL_SIZE +: IDX_X_WIDTH]};
	assign cur_tag = {cur_bx[BLK_X_WIDTH-1 -: TAG_X_WIDTH], cur_by[BLK_Y_WIDTH-1:IDX_Y_WIDTH]};
	assign hit = tag_valid[cur_index] && tag_mem[cur_index] == cur_tag;

	assign req_ready = state == ST_IDLE && !clear_busy;
	assign rsp_valid = state == ST_RESP;
	assign rsp_id = cur_id;
	assign fill_req_valid = state == ST_FILL_REQ;
	assign fill_req_bx = cur_bx;
	assign fill_req_by = cur_by;

	// --------------------------------------------------
	// request FSM
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			fill_row <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req_valid && req_ready) begin
						state <= ST_LOOKUP;
					end
				end
				ST_LOOKUP: begin
					state <= hit ? ST_READ : ST_FILL_REQ;
				end
				ST_FILL_REQ: begin
					fill_row <= '0;
					if (fill_req_ready) begin
						state <= ST_FILL;
					end
				end
				ST_FILL: begin
					if (fill_wvalid) begin
						fill_row <= fill_row + 1'b1;
						// look up again, the line now hits
						if (fill_wlast) begin
							state <= ST_LOOKUP;
						end
					end
				end
				ST_READ: begin
					state <= ST_RESP;
				end
				ST_RESP: begin
					if (rsp_ready) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// --------------------------------------------------
	// tag valid bits and clear sweep
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			tag_valid <= '0;
			clear_busy <= 1'b0;
			clear_idx <= '0;
		end else begin
			if (state == ST_FILL && fill_wvalid && fill_wlast) begin
				tag_valid[cur_index] <= 1'b1;
			end
			if (clear_start) begin
				clear_busy <= 1'b1;
				clear_idx <= '0;
			end else if (clear_busy) begin
				// one index per cycle
				tag_valid[clear_idx] <= 1'b0;
				clear_idx <= clear_idx + 1'b1;
				if (&clear_idx) begin
					clear_busy <= 1'b0;
				end
			end
		end
	end

	// arrays and payload
	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			cur_x <= req_x;
			cur_y <= req_y;
			cur_id <= req_id;
		end
		if (state == ST_FILL && fill_wvalid) begin
			data_mem[{cur_index, fill_row}] <= fill_wdata.word;
			if (fill_wlast) begin
				tag_mem[cur_index] <= cur_tag;
			end
		end
		if (state == ST_LOOKUP && hit) begin
			rd_word.word <= data_mem[{cur_index, cur_y[BLK_Y_SIZE-1:0]}];
		end
		if (state == ST_READ) begin
			// low x bits pick the texel within the row word
			rsp_texel <= rd_word.texels[cur_x[BLK_X_SIZE-1:0]];
		end
	end

	// burst words only go to the unit waiting on them
	assert property (@(posedge clk) disable iff (reset)
		fill_wvalid |-> state == ST_FILL);

endmodule

`default_nettype wire

// File: source/client_crossbar.sv
/*
 * client crossbar
 * routes requests to the owning cache unit, merges the
 * unit responses round-robin into one output register
 */
`timescale 1ns/1ns
`default_nettype none

module client_crossbar #(
	parameter int PARALLEL_SIZE = 1,
	localparam int UNIT_NUM = 1 << PARALLEL_SIZE
) (
	input wire clk,
	input wire reset,
	input wire tex_cache_pkg::addr_x_t s_araddrx,
	input wire tex_cache_pkg::addr_y_t s_araddry,
	input wire tex_cache_pkg::req_id_t s_arid,
	input wire s_arvalid,
	output logic s_arready,
	output tex_cache_pkg::texel_t s_rdata,
	output tex_cache_pkg::req_id_t s_rid,
	output logic s_rvalid,
	input wire s_rready,
	output tex_cache_pkg::addr_x_t [UNIT_NUM-1:0] unit_req_x,
	output tex_cache_pkg::addr_y_t [UNIT_NUM-1:0] unit_req_y,
	output tex_cache_pkg::req_id_t [UNIT_NUM-1:0] unit_req_id,
	output logic [UNIT_NUM-1:0] unit_req_valid,
	input wire [UNIT_NUM-1:0] unit_req_ready,
	input wire tex_cache_pkg::texel_t [UNIT_NUM-1:0] unit_rsp_texel,
	input wire tex_cache_pkg::req_id_t [UNIT_NUM-1:0] unit_rsp_id,
	input wire [UNIT_NUM-1:0] unit_rsp_valid,
	output logic [UNIT_NUM-1:0] unit_rsp_ready
);
	import tex_cache_pkg::*;

	blk_x_t in_bx;
	blk_y_t in_by;
	blk_x_t blk_sum;
	logic [PARALLEL_SIZE-1:0] in_unit;
	logic accept;
	logic [PARALLEL_SIZE-1:0] rr_ptr;
	logic [PARALLEL_SIZE-1:0] pick;
	logic pick_valid;
	logic out_free;

	// --------------------------------------------------
	// request side
	// --------------------------------------------------
	assign in_bx = s_araddrx[ADDR_X_WIDTH-1:BLK_X_SIZE];
	assign in_by = s_araddry[ADDR_Y_WIDTH-1:BLK_Y_SIZE];

	// owner is the low bits of bx + by
	assign blk_sum = in_bx + blk_x_t'(in_by);
	assign in_unit = blk_sum[PARALLEL_SIZE-1:0];

	assign s_arready = !unit_req_valid[in_unit] || unit_req_ready[in_unit];
	assign accept = s_arvalid && s_arready;

	always_ff @(posedge clk) begin
		if (reset) begin
			unit_req_valid <= '0;
		end else begin
			for (int i = 0; i < UNIT_NUM; i++) begin
				if (accept && in_unit == PARALLEL_SIZE'(i)) begin
					unit_req_valid[i] <= 1'b1;
				end else if (unit_req_ready[i]) begin
					unit_req_valid[i] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			unit_req_x[in_unit] <= s_araddrx;
			unit_req_y[in_unit] <= s_araddry;
			unit_req_id[in_unit] <= s_arid;
		end
	end

	// --------------------------------------------------
	// response side
	// --------------------------------------------------
	assign out_free = !s_rvalid || s_rready;

	// first valid unit at or after the pointer
	always_comb begin
		logic [PARALLEL_SIZE-1:0] cand;
		pick = rr_ptr;
		pick_valid = 1'b0;
		for (int k = UNIT_NUM - 1; k >= 0; k--) begin
			cand = rr_ptr + PARALLEL_SIZE'(k);
			if (unit_rsp_valid[cand]) begin
				pick = cand;
				pick_valid = 1'b1;
			end
		end
	end

	always_comb begin
		unit_rsp_ready = '0;
		unit_rsp_ready[pick] = out_free && pick_valid;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s_rvalid <= 1'b0;
			rr_ptr <= '0;
		end else if (out_free) begin
			s_rvalid <= pick_valid;
			if (pick_valid) begin
				rr_ptr <= pick + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (out_free && pick_valid) begin
			s_rdata <= unit_rsp_texel[pick];
			s_rid <= unit_rsp_id[pick];
		end
	end

	// a stalled response stays put until the client takes it
	assert property (@(posedge clk) disable iff (reset)
		s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rid));

endmodule

`default_nettype wire

// File: source/tex_cache_pkg.sv
/*
 * shared widths and types of the L2 texture cache
 * texel and block coordinates, request id, memory address
 * and the memory word union
 */
`default_nettype none

package tex_cache_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	localparam int ADDR_X_WIDTH = 8;
	localparam int ADDR_Y_WIDTH = 8;

	// log2 of block width and height in texels
	localparam int BLK_X_SIZE = 2;
	localparam int BLK_Y_SIZE = 2;

	localparam int TEXEL_WIDTH = 8;
	localparam int WORD_WIDTH = 32;
	localparam int TEXELS_PER_WORD = 4;

	// one word per texel row, also the burst length
	localparam int BLK_WORDS = 4;

	localparam int ID_WIDTH = 4;
	localparam int MEM_ADDR_WIDTH = 16;

	localparam int BLK_X_WIDTH = ADDR_X_WIDTH - BLK_X_SIZE;
	localparam int BLK_Y_WIDTH = ADDR_Y_WIDTH - BLK_Y_SIZE;

	// --------------------------------------------------
	// types
	// --------------------------------------------------
	typedef logic [ADDR_X_WIDTH-1:0] addr_x_t;
	typedef logic [ADDR_Y_WIDTH-1:0] addr_y_t;
	typedef logic [BLK_X_WIDTH-1:0] blk_x_t;
	typedef logic [BLK_Y_WIDTH-1:0] blk_y_t;
	typedef logic [TEXEL_WIDTH-1:0] texel_t;
	typedef logic [ID_WIDTH-1:0] req_id_t;
	typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;

	// stored and moved as a word, read out texel by texel
	typedef union packed {
		logic [WORD_WIDTH-1:0] word;
		texel_t [TEXELS_PER_WORD-1:0] texels;
	} mem_word_u;

endpackage

`default_nettype wire
